// ==== Makefile ====
# Verilator build and run of the alu_core testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_core
FILELIST  ?= alu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# a nonzero exit or the fail line in the log fails the target
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== adder_subtractor.sv ====
// combinational; carry after a subtract means no borrow, and addpsnx always returns carry 0
`timescale 1ns/1ps

module adder_subtractor
(
	input  alu_pkg::addsub_op_t op,
	input  alu_pkg::operands_t  opnds,
	input  logic                carry_in,
	output alu_pkg::pair_t      sum,
	output logic                carry_out
);

	import alu_pkg::*;

	// operation class
	logic is_sub;
	logic byte_op;
	// carry into bit 0
	logic cin;
	// second operand, after inversion or sign extension
	byte_t byte_b;
	pair_t pair_b;
	pair_t snx_b;
	// top bit of each sum is the carry
	logic [alu_width:0]  byte_res;
	logic [pair_width:0] pair_res;

	assign is_sub  = (op == as_sub) || (op == as_sbc) || (op == as_subp);
	assign byte_op = (op == as_add) || (op == as_adc) || (op == as_sub) || (op == as_sbc);

	// b.lo widened with its sign bit
	assign snx_b = pair_t'({{alu_width{opnds.b.lo[alu_width-1]}}, opnds.b.lo});

	// adc and sbc chain the stored carry
	// plain subtracts add the +1 of the two's complement
	always_comb
	begin
		case (op)
			as_adc, as_sbc:  cin = carry_in;
			as_sub, as_subp: cin = 1'b1;
			default:         cin = 1'b0;
		endcase
	end

	// a - b done as a + ~b + 1
	assign byte_b = is_sub ? ~opnds.b.lo : opnds.b.lo;

	always_comb
	begin
		if (op == as_addpsnx)
			pair_b = snx_b;
		else if (is_sub)
			pair_b = ~opnds.b;
		else
			pair_b = opnds.b;
	end

	// one byte adder, one pair adder
	assign byte_res = {1'b0, opnds.a.lo} + {1'b0, byte_b} + {{alu_width{1'b0}}, cin};
	assign pair_res = {1'b0, opnds.a} + {1'b0, pair_b} + {{pair_width{1'b0}}, cin};

	always_comb
	begin
		if (byte_op)
		begin
			// 8-bit ops clear hi
			sum       = '{hi: '0, lo: byte_res[alu_width-1:0]};
			carry_out = byte_res[alu_width];
		end
		else if ((op == as_addp) || (op == as_subp))
		begin
			sum       = pair_t'(pair_res[pair_width-1:0]);
			carry_out = pair_res[pair_width];
		end
		else if (op == as_addpsnx)
		begin
			// sum kept, carry dropped
			sum       = pair_t'(pair_res[pair_width-1:0]);
			carry_out = 1'b0;
		end
		else
		begin
			// spare encoding, never selected by the alu
			sum       = '0;
			carry_out = 1'b0;
		end
	end

	// hi of an 8-bit op must never leak into the pair result
	always_comb
	begin
		assert final (!byte_op || (sum.hi == '0))
			else $error("adder_subtractor: 8-bit op %s gave hi %h", op.name(), sum.hi);
	end

endmodule

// ==== alu.sv ====
// combinational; unused opcodes return the a pair with flags untouched, z covers hi only for pair ops
`timescale 1ns/1ps

module alu
(
	input  alu_pkg::alu_op_t    op,
	input  alu_pkg::operands_t  opnds,
	input  flags_pkg::flags_t   flags_in,
	output alu_pkg::pair_t      result,
	output flags_pkg::flags_t   flags_out
);

	import alu_pkg::*;
	import flags_pkg::*;

	// which block answers the opcode
	typedef enum logic [1:0] { unit_addsub, unit_shift, unit_logic, unit_none } unit_t;

	unit_t        unit;
	addsub_op_t   as_op;
	shift_op_t    sh_op;
	op_width_t    width;
	flag_update_t update;

	pair_t as_sum;
	logic  as_carry;
	pair_t sh_result;
	logic  sh_carry;
	flag_update_t sh_update;
	byte_t logic_lo;
	logic  carry;

	adder_subtractor u_addsub
	(
		.op        (as_op),
		.opnds     (opnds),
		.carry_in  (flags_in.c),
		.sum       (as_sum),
		.carry_out (as_carry)
	);

	// count always comes from b.lo
	shift_rotate_unit u_shift
	(
		.op        (sh_op),
		.a         (opnds.a),
		.count     (opnds.b.lo),
		.carry_in  (flags_in.c),
		.shifted   (sh_result),
		.carry_out (sh_carry),
		.update    (sh_update)
	);

	// unit and zero width
	always_comb
	begin
		unit  = unit_none;
		width = width_8;
		case (op)
			op_add, op_adc, op_sub, op_sbc:
				unit = unit_addsub;
			op_addp, op_subp, op_addpsnx:
			begin
				unit  = unit_addsub;
				width = width_pair;
			end
			op_and, op_orr, op_xor, op_inv:
				unit = unit_logic;
			op_lsl, op_lsr, op_asr, op_rol, op_ror, op_rolc, op_rorc:
				unit = unit_shift;
			default:
				unit = unit_none;
		endcase
	end

	// internal codes, don't care outside their unit
	always_comb
	begin
		case (op)
			op_adc:     as_op = as_adc;
			op_addp:    as_op = as_addp;
			op_addpsnx: as_op = as_addpsnx;
			op_sub:     as_op = as_sub;
			op_sbc:     as_op = as_sbc;
			op_subp:    as_op = as_subp;
			default:    as_op = as_add;
		endcase
	end

	always_comb
	begin
		case (op)
			op_lsr:  sh_op = sh_lsr;
			op_asr:  sh_op = sh_asr;
			op_rol:  sh_op = sh_rol;
			op_ror:  sh_op = sh_ror;
			op_rolc: sh_op = sh_rolc;
			op_rorc: sh_op = sh_rorc;
			default: sh_op = sh_lsl;
		endcase
	end

	// logic ops on the lo bytes
	always_comb
	begin
		case (op)
			op_and:  logic_lo = opnds.a.lo & opnds.b.lo;
			op_orr:  logic_lo = opnds.a.lo | opnds.b.lo;
			op_xor:  logic_lo = opnds.a.lo ^ opnds.b.lo;
			op_inv:  logic_lo = ~opnds.a.lo;
			default: logic_lo = '0;
		endcase
	end

	// result and carry select
	always_comb
	begin
		case (unit)
			unit_addsub:
			begin
				result = as_sum;
				carry  = as_carry;
				update = flags_compute;
			end
			unit_shift:
			begin
				result = sh_result;
				carry  = sh_carry;
				update = sh_update;
			end
			unit_logic:
			begin
				// logic ops never touch carry
				result = '{hi: '0, lo: logic_lo};
				carry  = flags_in.c;
				update = flags_compute;
			end
			default:
			begin
				result = opnds.a;
				carry  = flags_in.c;
				update = flags_hold;
			end
		endcase
	end

	// zero flag
	always_comb
	begin
		flags_out.c = carry;
		if (update == flags_hold)
			flags_out.z = flags_in.z;
		else if (width == width_pair)
			flags_out.z = (result == '0);
		else
			flags_out.z = (result.lo == '0);
	end

endmodule

// ==== alu_core.f ====
alu_pkg.sv
flags_pkg.sv
adder_subtractor.sv
shift_rotate_unit.sv
alu.sv
alu_core.sv
tb_alu_core.sv

// ==== alu_core.sv ====
// one-cycle registered ALU stage; no back-pressure, a new exec may come every cycle
`timescale 1ns/1ps

module alu_core
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                exec,
	input  alu_pkg::alu_op_t    op,
	input  alu_pkg::operands_t  opnds,
	output alu_pkg::pair_t      result,
	output flags_pkg::flags_t   flags,
	output logic                done
);

	import alu_pkg::*;
	import flags_pkg::*;

	// combinational answer for the current op
	pair_t  alu_result;
	flags_t alu_flags;

	// flag register fed back, so carry chains run back to back
	alu u_alu
	(
		.op        (op),
		.opnds     (opnds),
		.flags_in  (flags),
		.result    (alu_result),
		.flags_out (alu_flags)
	);

	// done follows exec by one cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= exec;
	end

	// result and flags only move on exec
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			result <= '0;
			flags  <= '0;
		end
		else if (exec)
		begin
			result <= alu_result;
			flags  <= alu_flags;
		end
	end

	// done only ever answers an exec one cycle earlier
	assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(exec))
		else $error("alu_core: done without a preceding exec");

endmodule

// ==== alu_pkg.sv ====
// fixed 8-bit datapath with 16-bit hi:lo pairs; rotate masking only works while alu_width is a power of two
package alu_pkg;

	// byte width, fixed by the instruction set
	localparam int alu_width = 8;
	// hi:lo register pair
	localparam int pair_width = 2 * alu_width;
	// count mask for 8-bit rotates
	// count modulo alu_width, power of two only
	localparam int rot_mask = alu_width - 1;

	// one register
	typedef logic [alu_width-1:0] byte_t;

	// register pair, hi is the upper byte
	typedef struct packed {
		byte_t hi;
		byte_t lo;
	} pair_t;

	// both source pairs of one operation
	typedef struct packed {
		pair_t a;
		pair_t b;
	} operands_t;

	// external opcodes
	// codes 18 to 31 are unused and act as a hold
	typedef enum logic [4:0] {
		op_add     = 5'd0,
		op_adc     = 5'd1,
		op_addp    = 5'd2,
		op_addpsnx = 5'd3,
		op_sub     = 5'd4,
		op_sbc     = 5'd5,
		op_subp    = 5'd6,
		op_and     = 5'd7,
		op_orr     = 5'd8,
		op_xor     = 5'd9,
		op_inv     = 5'd10,
		op_lsl     = 5'd11,
		op_lsr     = 5'd12,
		op_asr     = 5'd13,
		op_rol     = 5'd14,
		op_ror     = 5'd15,
		op_rolc    = 5'd16,
		op_rorc    = 5'd17
	} alu_op_t;

	// adder/subtractor operations
	typedef enum logic [2:0] {
		as_add, as_adc, as_addp, as_addpsnx, as_sub, as_sbc, as_subp
	} addsub_op_t;

	// shift/rotate operations
	typedef enum logic [2:0] {
		sh_lsl, sh_lsr, sh_asr, sh_rol, sh_ror, sh_rolc, sh_rorc
	} shift_op_t;

	// which result bits decide the zero flag
	typedef enum logic { width_8, width_pair } op_width_t;

endpackage

// ==== flags_pkg.sv ====
// processor flags are only carry and zero; no sign or overflow flag exists
package flags_pkg;

	// flag register layout
	// c is bit 1, z is bit 0
	typedef struct packed {
		// carry out, or no-borrow on subtracts
		logic c;
		// result zero, width picked per opcode
		logic z;
	} flags_t;

	// per-operation flag behaviour
	// hold passes the whole flag word and the a pair through
	typedef enum logic {
		flags_compute,
		flags_hold
	} flag_update_t;

endpackage

// ==== shift_rotate_unit.sv ====
// combinational 8-bit shifts and rotates; a zero count on lsl/lsr/asr/rol/ror holds a and flags
`timescale 1ns/1ps

module shift_rotate_unit
(
	input  alu_pkg::shift_op_t       op,
	input  alu_pkg::pair_t           a,
	input  alu_pkg::byte_t           count,
	input  logic                     carry_in,
	output alu_pkg::pair_t           shifted,
	output logic                     carry_out,
	output flags_pkg::flag_update_t  update
);

	import alu_pkg::*;
	import flags_pkg::*;

	// ops that take a count
	logic counted_op;
	logic count_zero;
	// count modulo alu_width for rotates
	byte_t rot_amt;
	// byte plus one carry position
	logic [alu_width:0] ext;
	// a.lo twice, so a shift of it is a rotate
	logic [pair_width-1:0] rot_buf;

	assign counted_op = (op == sh_lsl) || (op == sh_lsr) || (op == sh_asr)
		|| (op == sh_rol) || (op == sh_ror);
	assign count_zero = (count == '0);
	assign rot_amt    = count & byte_t'(rot_mask);

	always_comb
	begin
		ext       = '0;
		rot_buf   = '0;
		shifted   = '0;
		carry_out = carry_in;
		update    = flags_compute;

		if ((count_zero && counted_op) || (op > sh_rorc))
		begin
			// nothing changes, hi included
			shifted = a;
			update  = flags_hold;
		end
		else
		begin
			case (op)
				sh_lsl:
				begin
					// bit 8 catches the last bit out, 0 past a count of 8
					ext        = {1'b0, a.lo} << count;
					shifted.lo = ext[alu_width-1:0];
					carry_out  = ext[alu_width];
				end
				sh_lsr:
				begin
					// bit 0 catches the last bit out
					ext        = {a.lo, 1'b0} >> count;
					shifted.lo = ext[alu_width:1];
					carry_out  = ext[0];
				end
				sh_asr:
				begin
					// sign fills in, so past 8 the carry is the sign bit
					ext        = $signed({a.lo, 1'b0}) >>> count;
					shifted.lo = ext[alu_width:1];
					carry_out  = ext[0];
				end
				sh_rol:
				begin
					// top half of the doubled byte, carry untouched
					rot_buf    = {a.lo, a.lo} << rot_amt;
					shifted.lo = rot_buf[pair_width-1 -: alu_width];
				end
				sh_ror:
				begin
					// bottom half, carry untouched
					rot_buf    = {a.lo, a.lo} >> rot_amt;
					shifted.lo = rot_buf[alu_width-1:0];
				end
				sh_rolc:
				begin
					// 9-bit carry:lo rotated left by one
					{carry_out, shifted.lo} = {a.lo, carry_in};
				end
				default:
				begin
					// rorc, 9-bit carry:lo rotated right by one
					{shifted.lo, carry_out} = {carry_in, a.lo};
				end
			endcase
		end
	end

	// a hold must return the source pair untouched
	always_comb
	begin
		assert final ((update != flags_hold) || (shifted == a))
			else $error("shift_rotate_unit: hold on %s changed %h to %h",
				op.name(), a, shifted);
	end

endmodule

// ==== tb_alu_core.sv ====
// table rows run back to back, then 200 LCG ops one at a time; each exec must answer with done one cycle later
`timescale 1ns/1ps

module tb_alu_core;

	import alu_pkg::*;
	import flags_pkg::*;

	// one table entry with stimulus and expected answer
	typedef struct packed {
		alu_op_t   op;
		operands_t opnds;
		pair_t     res;
		flags_t    flg;
	} row_t;

	// predicted answer of the model
	typedef struct packed {
		pair_t  res;
		flags_t flg;
	} outcome_t;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      exec;
	alu_op_t   op;
	operands_t opnds;
	pair_t     result;
	flags_t    flags;
	logic      done;

	row_t        table_rows[$];
	logic [31:0] rng_state = 32'h983;
	// flag register as the model sees it
	flags_t      model_flags;
	int          value_errors;
	int          timeouts;

	alu_core DUT
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.exec   (exec),
		.op     (op),
		.opnds  (opnds),
		.result (result),
		.flags  (flags),
		.done   (done)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// LCG step
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic void add_row(alu_op_t o, logic [15:0] a, logic [15:0] b,
		logic [15:0] res, logic [1:0] flg);
		row_t r;
		r.op    = o;
		r.opnds = operands_t'({a, b});
		r.res   = pair_t'(res);
		r.flg   = flags_t'(flg);
		table_rows.push_back(r);
	endfunction

	// flags written as {c, z}
	function automatic void build_table();
		// carry chains set by one row and used by the next
		add_row(op_add,     16'h55F0, 16'h0020, 16'h0010, 2'b10);
		add_row(op_adc,     16'h0001, 16'h0001, 16'h0003, 2'b00);
		add_row(op_add,     16'h0080, 16'h0080, 16'h0000, 2'b11);
		add_row(op_adc,     16'h00FF, 16'h0000, 16'h0000, 2'b11);
		add_row(op_sub,     16'h0005, 16'h0003, 16'h0002, 2'b10);
		add_row(op_sbc,     16'h0010, 16'h0010, 16'h0000, 2'b11);
		add_row(op_sub,     16'h0003, 16'h0005, 16'h00FE, 2'b00);
		add_row(op_sbc,     16'h0010, 16'h0001, 16'h000E, 2'b10);
		// pair ops decide z over the whole pair
		add_row(op_addp,    16'hFF80, 16'h0080, 16'h0000, 2'b11);
		add_row(op_subp,    16'h1000, 16'h007F, 16'h0F81, 2'b10);
		add_row(op_subp,    16'h0100, 16'h0000, 16'h0100, 2'b10);
		add_row(op_addp,    16'h0F81, 16'h007F, 16'h1000, 2'b00);
		add_row(op_subp,    16'h0080, 16'h0080, 16'h0000, 2'b11);
		add_row(op_addpsnx, 16'h1234, 16'h0080, 16'h11B4, 2'b00);
		add_row(op_addpsnx, 16'h0081, 16'hAA7F, 16'h0100, 2'b00);
		add_row(op_addpsnx, 16'h0080, 16'h0080, 16'h0000, 2'b01);
		// logic ops keep carry
		add_row(op_add,     16'h00FF, 16'h0001, 16'h0000, 2'b11);
		add_row(op_and,     16'hAA0F, 16'h00F0, 16'h0000, 2'b11);
		add_row(op_orr,     16'h0F00, 16'h0001, 16'h0001, 2'b10);
		add_row(op_xor,     16'h00A5, 16'h00A5, 16'h0000, 2'b11);
		// count 0 holds and z stays set although a is not zero
		add_row(op_lsl,     16'h1281, 16'h0000, 16'h1281, 2'b11);
		add_row(op_inv,     16'h3300, 16'h0000, 16'h00FF, 2'b10);
		add_row(op_lsl,     16'h0081, 16'h0001, 16'h0002, 2'b10);
		add_row(op_lsl,     16'h0081, 16'h0008, 16'h0000, 2'b11);
		add_row(op_lsl,     16'h0081, 16'h0009, 16'h0000, 2'b01);
		add_row(op_lsr,     16'h0081, 16'h0001, 16'h0040, 2'b10);
		add_row(op_lsr,     16'h0080, 16'h0008, 16'h0000, 2'b11);
		add_row(op_lsr,     16'h00FF, 16'h0009, 16'h0000, 2'b01);
		add_row(op_asr,     16'h0081, 16'h0001, 16'h00C0, 2'b10);
		add_row(op_asr,     16'h0080, 16'h0009, 16'h00FF, 2'b10);
		add_row(op_asr,     16'h4040, 16'h0000, 16'h4040, 2'b10);
		// rotate by 8 is a full turn
		add_row(op_rol,     16'h77C3, 16'h0008, 16'h00C3, 2'b10);
		add_row(op_ror,     16'h00C3, 16'h0008, 16'h00C3, 2'b10);
		add_row(op_rol,     16'h0081, 16'h0001, 16'h0003, 2'b10);
		add_row(op_ror,     16'h0081, 16'h0009, 16'h00C0, 2'b10);
		add_row(op_rol,     16'h5A5A, 16'h0000, 16'h5A5A, 2'b10);
		// carry moves through the 9-bit rotate
		add_row(op_rolc,    16'h0000, 16'h0000, 16'h0001, 2'b00);
		add_row(op_rolc,    16'h0080, 16'h0000, 16'h0000, 2'b11);
		add_row(op_rorc,    16'h0000, 16'h0000, 16'h0080, 2'b00);
		add_row(op_rorc,    16'h0001, 16'h0000, 16'h0000, 2'b11);
		add_row(op_ror,     16'h1234, 16'h0000, 16'h1234, 2'b11);
		// unused code holds
		add_row(alu_op_t'(5'd20), 16'hBEEF, 16'h0102, 16'hBEEF, 2'b11);
	endfunction

	// reference model
	function automatic outcome_t predict(alu_op_t o, operands_t d, flags_t f);
		outcome_t   r;
		int         sum;
		int         n;
		logic [7:0] al;
		logic [7:0] tmp;
		logic       hold;
		logic       pair_op;
		al      = d.a.lo;
		n       = int'(d.b.lo);
		hold    = 1'b0;
		pair_op = 1'b0;
		r.res   = '0;
		r.flg   = f;
		case (o)
			op_add, op_adc:
			begin
				sum      = int'(al) + int'(d.b.lo) + ((o == op_adc) ? int'(f.c) : 0);
				r.res.lo = sum[7:0];
				r.flg.c  = (sum > 255);
			end
			op_sub, op_sbc:
			begin
				// clear carry on sbc means a pending borrow
				sum      = int'(al) - int'(d.b.lo) - (((o == op_sbc) && !f.c) ? 1 : 0);
				r.res.lo = sum[7:0];
				r.flg.c  = (sum >= 0);
			end
			op_addp, op_subp, op_addpsnx:
			begin
				pair_op = 1'b1;
				if (o == op_addp)
					sum = int'(d.a) + int'(d.b);
				else if (o == op_subp)
					sum = int'(d.a) - int'(d.b);
				else
					sum = int'(d.a) + int'(signed'(d.b.lo));
				r.res   = pair_t'(sum[15:0]);
				r.flg.c = (o == op_addp) ? (sum > 65535) : ((o == op_subp) ? (sum >= 0) : 1'b0);
			end
			op_and: r.res.lo = al & d.b.lo;
			op_orr: r.res.lo = al | d.b.lo;
			op_xor: r.res.lo = al ^ d.b.lo;
			op_inv: r.res.lo = ~al;
			op_lsl, op_lsr, op_asr:
			begin
				if (n == 0)
					hold = 1'b1;
				else if (n <= 8)
				begin
					// last bit out
					tmp      = (o == op_lsl) ? (al >> (8 - n)) : (al >> (n - 1));
					r.flg.c  = tmp[0];
					if (o == op_lsl)
						r.res.lo = al << n;
					else if (o == op_lsr)
						r.res.lo = al >> n;
					else
						r.res.lo = $signed(al) >>> n;
				end
				else
				begin
					// everything shifted out and asr leaves the sign
					r.flg.c  = (o == op_asr) ? al[7] : 1'b0;
					r.res.lo = (o == op_asr) ? {8{al[7]}} : 8'h00;
				end
			end
			op_rol, op_ror:
			begin
				if (n == 0)
					hold = 1'b1;
				else if (o == op_rol)
					r.res.lo = (al << (n % 8)) | (al >> (8 - (n % 8)));
				else
					r.res.lo = (al >> (n % 8)) | (al << (8 - (n % 8)));
			end
			op_rolc:
			begin
				r.res.lo = {al[6:0], f.c};
				r.flg.c  = al[7];
			end
			op_rorc:
			begin
				r.res.lo = {f.c, al[7:1]};
				r.flg.c  = al[0];
			end
			default: hold = 1'b1;
		endcase
		if (hold)
		begin
			r.res = d.a;
			r.flg = f;
		end
		else if (pair_op)
			r.flg.z = (r.res == '0);
		else
			r.flg.z = (r.res.lo == '0);
		return r;
	endfunction

	task automatic check_pair(input pair_t got, input pair_t want, input string what);
		if (got !== want)
		begin
			value_errors++;
			$display("error at %0t ns: %s result %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_flags(input flags_t got, input flags_t want, input string what);
		if (got !== want)
		begin
			value_errors++;
			$display("error at %0t ns: %s flags c=%b z=%b, expected c=%b z=%b",
				$time, what, got.c, got.z, want.c, want.z);
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		if (got !== want)
		begin
			value_errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	// exec and operands for the next edge
	task automatic drive_op(input alu_op_t o, input operands_t d);
		exec  <= 1'b1;
		op    <= o;
		opnds <= d;
	endtask

	// bounded wait for done
	// outputs are read at the edge before they move again
	task automatic wait_done(output logic seen, output int cycles);
		seen   = 1'b0;
		cycles = 0;
		while (!seen && (cycles < 16))
		begin
			@(posedge clk);
			cycles++;
			seen = done;
		end
	endtask

	// one exec strobe followed by a bounded wait for done
	task automatic issue_op(input alu_op_t o, input operands_t d, output logic seen,
		output int cycles);
		@(posedge clk);
		drive_op(o, d);
		@(posedge clk);
		exec <= 1'b0;
		wait_done(seen, cycles);
	endtask

	initial
	begin
		int          i;
		int          cycles;
		logic        seen;
		logic [31:0] r;
		alu_op_t     o;
		operands_t   d;
		outcome_t    want;
		string       tag;

		rst_n        <= 1'b0;
		exec         <= 1'b0;
		op           <= op_add;
		opnds        <= '0;
		value_errors = 0;
		timeouts     = 0;
		model_flags  = '0;
		build_table();

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		check_pair(result, '0, "after reset");
		check_flags(flags, '0, "after reset");
		check_bit(done, 1'b0, "done after reset");

		// exec stays high across the table
		// each row is checked while the next one is taken
		@(posedge clk);
		drive_op(table_rows[0].op, table_rows[0].opnds);
		@(posedge clk);
		for (i = 0; i < table_rows.size(); i++)
		begin
			want        = predict(table_rows[i].op, table_rows[i].opnds, model_flags);
			model_flags = want.flg;
			tag         = $sformatf("table row %0d", i);
			if (i + 1 < table_rows.size())
				drive_op(table_rows[i + 1].op, table_rows[i + 1].opnds);
			else
				exec <= 1'b0;
			wait_done(seen, cycles);
			if (!seen)
			begin
				timeouts++;
				$display("timeout: done never came for table row %0d", i);
			end
			else
			begin
				check_pair(result, table_rows[i].res, tag);
				check_flags(flags, table_rows[i].flg, tag);
			end
		end

		// random ops including unused codes
		for (i = 0; i < 200; i++)
		begin
			r = next_rand();
			o = alu_op_t'(r[31:27]);
			d = operands_t'(next_rand());
			// small counts half the time so shifts stay in range
			if (r[26])
				d.b.lo = {4'h0, r[25:22]};
			want        = predict(o, d, model_flags);
			model_flags = want.flg;
			tag         = $sformatf("random op %0d (code %0d)", i, r[31:27]);
			issue_op(o, d, seen, cycles);
			if (!seen)
			begin
				timeouts++;
				$display("timeout: done never came for random op %0d", i);
			end
			else
			begin
				if (cycles != 1)
				begin
					value_errors++;
					$display("error at %0t ns: %s done after %0d cycles, expected 1",
						$time, tag, cycles);
				end
				check_pair(result, want.res, tag);
				check_flags(flags, want.flg, tag);
			end
		end

		$display("checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
		if ((value_errors == 0) && (timeouts == 0))
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
